//--- serdes_data_pkg.sv
package serdes_data_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line data types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [7:0]  ser_word_t;                  // One parallel word on the line.
    typedef logic [15:0] err_count_t;                 // Saturating mismatch count.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fixed words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Alignment pattern. Each of its eight rotations is a different value,
    // so a repeated stream of it matches the shift register at one phase only.
    localparam ser_word_t TRAIN_WORD = 8'b1111_0000;

    // Filler for empty run slots. It can never be taken for the training word.
    localparam ser_word_t IDLE_WORD = 8'b0000_0000;

    // Largest count value, where the error counter stops.
    localparam err_count_t ERR_COUNT_MAX = '1;

endpackage

//--- serdes_ctrl_pkg.sv
package serdes_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer and checker records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        TRAIN     = 2'd0,                              // Sending the alignment pattern.
        RUN       = 2'd1,                              // Sending input or idle words.
        LOCK_FAIL = 2'd2                               // No lock in time, held until reset.
    } seq_state_t;

    typedef struct packed {
        logic                       is_data;           // Set when the slot carried an input word.
        serdes_data_pkg::ser_word_t word;              // Word as it left the serializer.
    } tx_entry_t;

    typedef struct packed {
        serdes_data_pkg::ser_word_t word;              // Word as it came back on ser_in.
        logic                       mismatch;          // Set when it differs from the sent word.
    } rx_report_t;

endpackage

//--- bit_timer.sv
`timescale 1ns/1ps

module bit_timer #(
    parameter int DATA_WIDTH    = 8,
    parameter int ALIGN_TIMEOUT = 64
) (
    input  logic                            CLK,
    input  logic                            rst_n,
    input  serdes_ctrl_pkg::seq_state_t     state,
    output logic [$clog2(DATA_WIDTH)-1:0]   bit_phase,
    output logic                            word_tick,
    output logic                            timeout
);

    localparam int PHASE_W = $clog2(DATA_WIDTH);
    localparam int WCNT_W  = $clog2(ALIGN_TIMEOUT + 1);

    logic [WCNT_W-1:0] word_count;                    // Training words spent on the lock attempt.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit phase and word counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            bit_phase  <= '0;
            word_count <= '0;
        end else begin
            bit_phase <= word_tick ? '0 : bit_phase + 1'b1;  // Wraps after the last bit.
            if (state != serdes_ctrl_pkg::TRAIN) begin
                word_count <= '0;                     // Only training time is limited.
            end else if (word_tick && !timeout) begin
                word_count <= word_count + 1'b1;      // Stops once the limit is reached.
            end
        end
    end

    assign word_tick = (bit_phase == PHASE_W'(DATA_WIDTH - 1));  // Last bit of the slot.
    assign timeout   = (word_count == WCNT_W'(ALIGN_TIMEOUT));   // Lock budget used up.

endmodule

//--- word_serializer.sv
`timescale 1ns/1ps

module word_serializer (
    input  logic                            CLK,
    input  logic                            rst_n,
    input  logic                            word_tick,
    input  logic                            load_data,
    input  logic                            load_train,
    input  serdes_data_pkg::ser_word_t      in_word,
    input  serdes_ctrl_pkg::seq_state_t     state,
    output logic                            ser_out,
    output logic                            ser_frame,
    output logic                            tx_push,
    output serdes_ctrl_pkg::tx_entry_t      tx_entry
);

    localparam int W = $bits(serdes_data_pkg::ser_word_t);

    serdes_data_pkg::ser_word_t next_word;            // Word chosen for the coming slot.
    serdes_data_pkg::ser_word_t shift_reg;            // MSB is the bit on the line.

    always_comb begin
        if (load_train) begin
            next_word = serdes_data_pkg::TRAIN_WORD;
        end else if (load_data) begin
            next_word = in_word;                      // Handshake took place this cycle.
        end else begin
            next_word = serdes_data_pkg::IDLE_WORD;   // Empty slot or lock failure.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shift out MSB first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            shift_reg <= '0;                          // Keeps the line low out of reset.
            ser_frame <= 1'b0;
        end else begin
            ser_frame <= word_tick;                   // High while the MSB is on the line.
            if (word_tick) begin
                shift_reg <= next_word;
            end else begin
                shift_reg <= shift_reg << 1;
            end
        end
    end

    assign ser_out = shift_reg[W-1];

    // Every run slot is recorded, idle ones included, so the checker stays in step.
    assign tx_push          = word_tick && (state == serdes_ctrl_pkg::RUN);
    assign tx_entry.is_data = load_data;
    assign tx_entry.word    = next_word;

endmodule

//--- word_deserializer.sv
`timescale 1ns/1ps

module word_deserializer #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                            CLK,
    input  logic                            rst_n,
    input  logic [$clog2(DATA_WIDTH)-1:0]   bit_phase,
    input  logic                            ser_in,
    output serdes_data_pkg::ser_word_t      rx_word,
    output logic                            rx_strobe,
    output logic                            locked
);

    localparam int PHASE_W = $clog2(DATA_WIDTH);

    serdes_data_pkg::ser_word_t shift_reg;            // Last DATA_WIDTH bits, oldest at the MSB.
    logic [PHASE_W-1:0]         word_phase;           // Phase where a whole word sits in shift_reg.
    logic                       cand_valid;           // A first pattern match has been seen.
    logic                       train_hit;

    assign train_hit = (shift_reg == serdes_data_pkg::TRAIN_WORD);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Phase search with two-match confirmation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            shift_reg  <= '0;
            word_phase <= '0;
            cand_valid <= 1'b0;
            locked     <= 1'b0;
        end else begin
            shift_reg <= {shift_reg[DATA_WIDTH-2:0], ser_in};   // New bit enters at the LSB.
            if (!locked && train_hit) begin
                if (cand_valid && (bit_phase == word_phase)) begin
                    locked <= 1'b1;                   // Same phase one word later confirms it.
                end else begin
                    word_phase <= bit_phase;          // New or moved candidate phase.
                    cand_valid <= 1'b1;
                end
            end
        end
    end

    // Once locked, the register holds one aligned word at each pass of word_phase.
    assign rx_strobe = locked && (bit_phase == word_phase);
    assign rx_word   = shift_reg;

    // Lock is kept until reset, since nothing here tries to relock.
    locked_holds: assert property (
        @(posedge CLK) disable iff (!rst_n)
        locked |=> locked
    ) else $error("word_deserializer lost lock without a reset.");

endmodule

//--- loopback_checker.sv
`timescale 1ns/1ps

module loopback_checker #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                            CLK,
    input  logic                            rst_n,
    input  logic                            tx_push,
    input  serdes_ctrl_pkg::tx_entry_t      tx_entry,
    input  serdes_data_pkg::ser_word_t      rx_word,
    input  logic                            rx_strobe,
    output serdes_ctrl_pkg::rx_report_t     rx_report,
    output logic                            rx_valid,
    output serdes_data_pkg::err_count_t     err_count
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    serdes_ctrl_pkg::tx_entry_t fifo_mem [FIFO_DEPTH];  // Sent slots not yet seen back.
    serdes_ctrl_pkg::tx_entry_t head;
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           fill;
    logic                       synced;               // First run slot has come back.
    logic                       drop;
    logic                       pop;
    logic                       word_diff;

    assign head = fifo_mem[rd_ptr];
    // Training words still on the loop are thrown away until the first run slot
    // arrives. That slot is idle, so it never looks like the training word.
    assign drop      = (fill == '0) || (!synced && (rx_word == serdes_data_pkg::TRAIN_WORD));
    assign pop       = rx_strobe && !drop;
    assign word_diff = (rx_word != head.word);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FIFO of sent slots
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK) begin
        if (tx_push) begin
            fifo_mem[wr_ptr] <= tx_entry;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            synced <= 1'b0;
        end else begin
            if (tx_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                synced <= 1'b1;
            end
            case ({tx_push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;                // Both or neither leave it unchanged.
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare and report
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK) begin
        if (pop) begin
            rx_report.word     <= rx_word;
            rx_report.mismatch <= word_diff;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            rx_valid  <= 1'b0;
            err_count <= '0;
        end else begin
            rx_valid <= pop && head.is_data;          // Idle slots pop without a report.
            if (pop && head.is_data && word_diff
                    && (err_count != serdes_data_pkg::ERR_COUNT_MAX)) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    // The loop must never hold more slots than the FIFO has room for.
    fifo_no_overflow: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (tx_push && !pop) |-> (fill != CNT_W'(FIFO_DEPTH))
    ) else $error("loopback_checker FIFO overflow, loop delay too long.");

    // Once in step, every word back belongs to a sent slot, so it always finds one to pop.
    fifo_no_underflow: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (rx_strobe && synced) |-> (fill != '0)
    ) else $error("loopback_checker got a word back with no sent slot to pop.");

endmodule

//--- test_sequencer.sv
`timescale 1ns/1ps

module test_sequencer #(
    parameter int EXTRA_TRAIN = 4
) (
    input  logic                            CLK,
    input  logic                            rst_n,
    input  logic                            word_tick,
    input  logic                            timeout,
    input  logic                            locked,
    input  logic                            in_valid,
    output logic                            in_ready,
    output serdes_ctrl_pkg::seq_state_t     state,
    output logic                            load_data,
    output logic                            load_train
);

    localparam int CNT_W = (EXTRA_TRAIN > 1) ? $clog2(EXTRA_TRAIN) : 1;

    logic [CNT_W-1:0] extra_cnt;                      // Training words loaded since lock.
    logic             guard_done;                     // First run slot has gone out idle.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Phase FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state      <= serdes_ctrl_pkg::TRAIN;
            extra_cnt  <= '0;
            guard_done <= 1'b0;
        end else begin
            case (state)
                serdes_ctrl_pkg::TRAIN: begin
                    if (timeout && !locked) begin
                        state <= serdes_ctrl_pkg::LOCK_FAIL;    // Budget spent without lock.
                    end else if (word_tick && locked) begin
                        if (extra_cnt == CNT_W'(EXTRA_TRAIN - 1)) begin
                            state <= serdes_ctrl_pkg::RUN;      // This slot is the last one.
                        end else begin
                            extra_cnt <= extra_cnt + 1'b1;
                        end
                    end
                end
                serdes_ctrl_pkg::RUN: begin
                    if (word_tick) begin
                        guard_done <= 1'b1;           // Marks where run slots start on the loop.
                    end
                end
                default: state <= serdes_ctrl_pkg::LOCK_FAIL;  // Held until reset.
            endcase
        end
    end

    assign load_train = word_tick && (state == serdes_ctrl_pkg::TRAIN);
    assign in_ready   = word_tick && (state == serdes_ctrl_pkg::RUN) && guard_done;
    assign load_data  = in_ready && in_valid;

endmodule

//--- serdes_test_top.sv
`timescale 1ns/1ps

module serdes_test_top #(
    parameter int DATA_WIDTH    = 8,
    parameter int ALIGN_TIMEOUT = 64,
    parameter int EXTRA_TRAIN   = 4,
    parameter int FIFO_DEPTH    = 16
) (
    input  logic                            CLK,
    input  logic                            rst_n,
    input  serdes_data_pkg::ser_word_t      in_word,
    input  logic                            in_valid,
    output logic                            in_ready,
    output logic                            ser_out,
    output logic                            ser_frame,
    input  logic                            ser_in,
    output serdes_ctrl_pkg::rx_report_t     rx_report,
    output logic                            rx_valid,
    output serdes_data_pkg::err_count_t     err_count,
    output logic                            locked,
    output logic                            lock_fail
);

    serdes_ctrl_pkg::seq_state_t     state;
    serdes_ctrl_pkg::tx_entry_t      tx_entry;
    serdes_data_pkg::ser_word_t      rx_word;
    logic [$clog2(DATA_WIDTH)-1:0]   bit_phase;
    logic                            word_tick;
    logic                            timeout;
    logic                            load_data;
    logic                            load_train;
    logic                            tx_push;
    logic                            rx_strobe;

    assign lock_fail = (state == serdes_ctrl_pkg::LOCK_FAIL);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmit side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    bit_timer #(
        .DATA_WIDTH    (DATA_WIDTH),
        .ALIGN_TIMEOUT (ALIGN_TIMEOUT)
    ) i_bit_timer (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .state     (state),
        .bit_phase (bit_phase),
        .word_tick (word_tick),
        .timeout   (timeout)
    );

    test_sequencer #(
        .EXTRA_TRAIN (EXTRA_TRAIN)
    ) i_test_sequencer (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .word_tick  (word_tick),
        .timeout    (timeout),
        .locked     (locked),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .state      (state),
        .load_data  (load_data),
        .load_train (load_train)
    );

    word_serializer i_word_serializer (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .word_tick  (word_tick),
        .load_data  (load_data),
        .load_train (load_train),
        .in_word    (in_word),
        .state      (state),
        .ser_out    (ser_out),
        .ser_frame  (ser_frame),
        .tx_push    (tx_push),
        .tx_entry   (tx_entry)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    word_deserializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_word_deserializer (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .bit_phase (bit_phase),
        .ser_in    (ser_in),
        .rx_word   (rx_word),
        .rx_strobe (rx_strobe),
        .locked    (locked)
    );

    loopback_checker #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_loopback_checker (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .tx_push   (tx_push),
        .tx_entry  (tx_entry),
        .rx_word   (rx_word),
        .rx_strobe (rx_strobe),
        .rx_report (rx_report),
        .rx_valid  (rx_valid),
        .err_count (err_count)
    );

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic                            CLK,
    input  logic                            rst_n,
    input  serdes_data_pkg::ser_word_t      in_word,
    input  serdes_data_pkg::ser_word_t      in_mask,
    input  logic                            in_valid,
    input  logic                            in_ready,
    input  serdes_ctrl_pkg::rx_report_t     rx_report,
    input  logic                            rx_valid,
    output int                              report_count,
    output int                              check_count,
    output int                              fail_count
);

    serdes_ctrl_pkg::rx_report_t exp_q [$];           // Reports still owed by the DUT.
    serdes_ctrl_pkg::rx_report_t expected;
    int                          reports = 0;
    int                          checks  = 0;
    int                          fails   = 0;

    assign report_count = reports;
    assign check_count  = checks;
    assign fail_count   = fails;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Expected reports from the input handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Sampled mid-cycle, where both inputs and DUT outputs have settled.
    always @(negedge CLK) begin
        if (rst_n && in_valid && in_ready) begin
            expected.word     = in_word ^ in_mask;    // The line flips the masked bits.
            expected.mismatch = (in_mask != '0);      // Any flip must be flagged.
            exp_q.push_back(expected);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare each report in order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge CLK) begin
        if (rst_n && rx_valid) begin
            reports = reports + 1;
            checks  = checks + 1;
            if (exp_q.size() == 0) begin
                fails = fails + 1;                    // Idle slot or duplicate came out.
                $display("[ERROR] %0t: report %0d with no word outstanding, word %h",
                         $time, reports, rx_report.word);
            end else begin
                expected = exp_q.pop_front();
                if (rx_report !== expected) begin
                    fails = fails + 1;
                    $display("[ERROR] %0t: report %0d got word %h mismatch %b, expected %h %b",
                             $time, reports, rx_report.word, rx_report.mismatch,
                             expected.word, expected.mismatch);
                end else begin
                    $display("word %0d: ok, %h mismatch %b", reports, rx_report.word,
                             rx_report.mismatch);
                end
            end
        end
    end

endmodule

//--- tb_serdes_test.sv
`timescale 1ns/1ps

module tb_serdes_test;

    localparam int DATA_WIDTH    = 8;
    localparam int ALIGN_TIMEOUT = 64;
    localparam int EXTRA_TRAIN   = 4;
    localparam int FIFO_DEPTH    = 16;
    localparam int NUM_VECTORS   = 16;                // Lines in serdes_vectors.txt.
    localparam int LOOP_DELAY    = 3;                 // Cycles from ser_out back to ser_in.
    localparam logic [31:0] SEED = 32'd46598;
    localparam int LOCK_LIMIT    = ALIGN_TIMEOUT * DATA_WIDTH + 50;
    localparam int FAIL_LIMIT    = (ALIGN_TIMEOUT + 2) * DATA_WIDTH;
    localparam int READY_LIMIT   = (EXTRA_TRAIN + 4) * DATA_WIDTH;
    localparam int DRAIN_LIMIT   = (FIFO_DEPTH + 4) * DATA_WIDTH;

    logic                          CLK;
    logic                          rst_n;
    serdes_data_pkg::ser_word_t    in_word;
    logic                          in_valid;
    logic                          in_ready;
    logic                          ser_out;
    logic                          ser_frame;
    logic                          ser_in = 1'b0;
    serdes_ctrl_pkg::rx_report_t   rx_report;
    logic                          rx_valid;
    serdes_data_pkg::err_count_t   err_count;
    logic                          locked;
    logic                          lock_fail;

    serdes_data_pkg::ser_word_t    in_mask;           // Flip mask that travels with in_word.
    logic                          loop_on;           // Low holds ser_in at 0.
    logic [LOOP_DELAY-1:0]         line_pipe = '0;    // Line bits on their way back.
    logic                          slot_data;         // The slot loaded last cycle is data.
    serdes_data_pkg::ser_word_t    frame_mask;        // Mask of the word now on the line.
    int                            frame_bit;
    serdes_data_pkg::ser_word_t    mask_q [$];        // Masks in acceptance order.
    logic [7:0]                    vec_mem [0:3*NUM_VECTORS-1];
    logic [31:0]                   rng;
    int                            exp_errors;
    int                            own_checks;
    int                            own_fails;
    int                            report_count;
    int                            check_count;
    int                            fail_count;
    bit                            run_ok;

    always #50 CLK = ~CLK;                            // 100 ns period.

    serdes_test_top #(
        .DATA_WIDTH    (DATA_WIDTH),
        .ALIGN_TIMEOUT (ALIGN_TIMEOUT),
        .EXTRA_TRAIN   (EXTRA_TRAIN),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) i_serdes_test_top (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .ser_out   (ser_out),
        .ser_frame (ser_frame),
        .ser_in    (ser_in),
        .rx_report (rx_report),
        .rx_valid  (rx_valid),
        .err_count (err_count),
        .locked    (locked),
        .lock_fail (lock_fail)
    );

    tb_checker i_tb_checker (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .in_word      (in_word),
        .in_mask      (in_mask),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .rx_report    (rx_report),
        .rx_valid     (rx_valid),
        .report_count (report_count),
        .check_count  (check_count),
        .fail_count   (fail_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Loopback line with error injection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge CLK) begin
        logic line_bit;
        if (!rst_n) begin
            line_pipe  = '0;                          // Nothing in flight after reset.
            slot_data  = 1'b0;
            frame_mask = '0;
            frame_bit  = 0;
            mask_q.delete();
        end else begin
            if (ser_frame) begin
                frame_mask = slot_data ? mask_q.pop_front() : '0;  // Only data slots flip.
                frame_bit  = DATA_WIDTH - 1;          // MSB is on the line now.
            end
            line_bit = ser_out ^ frame_mask[frame_bit];
            if (frame_bit > 0) begin
                frame_bit = frame_bit - 1;
            end
            line_pipe = {line_pipe[LOOP_DELAY-2:0], line_bit};
            slot_data = in_valid && in_ready;         // Transfer at the coming edge.
            if (slot_data) begin
                mask_q.push_back(in_mask);
            end
        end
    end

    always @(posedge CLK) begin
        #1;
        ser_in = loop_on ? line_pipe[LOOP_DELAY-1] : 1'b0;  // Oldest bit goes back in.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);                            // 32-bit xorshift.
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic score(input bit pass, input string name, input string detail);
        own_checks = own_checks + 1;
        if (pass) begin
            $display("%s: ok", name);
        end else begin
            own_fails = own_fails + 1;
            $display("[ERROR] %0t: %s, %s", $time, name, detail);
        end
    endtask

    task automatic apply_reset();
        @(posedge CLK);
        #1;
        rst_n = 1'b0;
        repeat (5) @(posedge CLK);                    // Five cycles in reset.
        #1;
        rst_n = 1'b1;
    endtask

    task automatic wait_for_lock(output bit ok);
        int n;
        bit saw_fail;
        ok       = 1'b0;
        saw_fail = 1'b0;
        for (n = 0; n < LOCK_LIMIT && !ok; n++) begin
            @(negedge CLK);
            saw_fail = saw_fail | lock_fail;
            ok       = locked;
        end
        if (!ok) begin
            $display("Timed out: locked did not rise within %0d cycles.", LOCK_LIMIT);
        end
        score(!saw_fail, "lock", "lock_fail rose while locking");
    endtask

    task automatic send_word(input logic [7:0] word, input logic [7:0] mask,
                             input int gap, output bit ok);
        int n;
        ok = 1'b0;
        repeat (gap) begin
            @(posedge CLK);
            #1;
        end
        in_word  = word;
        in_mask  = mask;
        in_valid = 1'b1;
        for (n = 0; n < READY_LIMIT && !ok; n++) begin
            @(negedge CLK);
            ok = in_ready;                            // Transfer at the next edge.
        end
        @(posedge CLK);
        #1;
        in_valid = 1'b0;
        if (!ok) begin
            $display("Timed out: in_ready never rose for word %h.", word);
        end
    endtask

    task automatic send_vectors(output bit ok);
        int i;
        ok = 1'b1;
        for (i = 0; i < NUM_VECTORS && ok; i++) begin
            if (vec_mem[3*i+1] != 8'h00) begin
                exp_errors = exp_errors + 1;          // Every flipped word is one error.
            end
            send_word(vec_mem[3*i], vec_mem[3*i+1], int'(vec_mem[3*i+2]) + int'(rng[1:0]), ok);
            rng = next_random(rng);
        end
    endtask

    task automatic drain_reports(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < DRAIN_LIMIT && !ok; n++) begin
            @(negedge CLK);
            ok = (report_count >= NUM_VECTORS);
        end
        if (!ok) begin
            $display("Timed out: only %0d of %0d reports came back.", report_count, NUM_VECTORS);
        end else begin
            repeat (4 * DATA_WIDTH) @(negedge CLK);   // Room for any stray report.
            score(report_count == NUM_VECTORS, "report count", "extra reports seen");
            score(err_count == serdes_data_pkg::err_count_t'(exp_errors), "error count",
                  $sformatf("err_count %0d, expected %0d", err_count, exp_errors));
        end
    endtask

    task automatic check_lock_failure(output bit ok);
        int n;
        bit stray;
        ok    = 1'b0;
        stray = 1'b0;
        loop_on = 1'b0;                               // Line stays dead, no pattern arrives.
        apply_reset();
        for (n = 0; n < FAIL_LIMIT && !ok; n++) begin
            @(negedge CLK);
            stray = stray | locked | rx_valid;
            ok    = lock_fail;
        end
        if (!ok) begin
            $display("Timed out: lock_fail did not rise within %0d cycles.", FAIL_LIMIT);
        end
        score(!stray, "lock failure", "locked or rx_valid rose on a dead line");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        CLK        = 1'b0;
        rst_n      = 1'b0;
        in_word    = '0;
        in_valid   = 1'b0;
        in_mask    = '0;
        loop_on    = 1'b1;
        rng        = SEED;
        exp_errors = 0;
        own_checks = 0;
        own_fails  = 0;
        $readmemh("serdes_vectors.txt", vec_mem);
        apply_reset();
        wait_for_lock(run_ok);
        if (run_ok) begin
            send_vectors(run_ok);
        end
        if (run_ok) begin
            drain_reports(run_ok);
        end
        if (run_ok) begin
            check_lock_failure(run_ok);
        end
        $display("Summary: %0d checks, %0d errors", own_checks + check_count,
                 own_fails + fail_count);
        if (run_ok && (own_fails + fail_count) == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- serdes_vectors.txt
// Columns (hex): data word, flip mask, idle cycles before the word.
// A nonzero mask corrupts the looped-back copy, which must then be flagged.
a5 00 0
3c 00 0
ff 00 2
00 00 0
5a 01 1
81 00 0
c3 80 3
7e 00 0
12 ff 5
34 00 0
f0 00 1
0f 18 0
96 00 9
69 42 0
e7 00 2
18 00 0

//--- files.f
serdes_data_pkg.sv
serdes_ctrl_pkg.sv
bit_timer.sv
word_serializer.sv
word_deserializer.sv
loopback_checker.sv
test_sequencer.sv
serdes_test_top.sv
tb_checker.sv
tb_serdes_test.sv

//--- run_sim.sh
#!/bin/sh
# Build the loopback testbench with Verilator, run it and scan the log.
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_serdes_test \
    -o tb_serdes_test > build.log 2>&1 \
    && ./obj_dir/tb_serdes_test > sim.log 2>&1 \
    || echo "Test failed" >> sim.log
if grep -q "Test failed" sim.log; then
    echo "Simulation failed, see sim.log and build.log."
    exit 1
fi
echo "Simulation passed."
exit 0
